//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       := tb_conv_output_stage
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
PASS_MSG  := TESTBENCH PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only when the pass message shows up in the output.
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bias_relu.sv
`default_nettype none

module bias_relu #(
    // default is +2.0.
    parameter cnn_pkg::float_t BIAS =
        cnn_pkg::float_t'((cnn_pkg::FLOAT_BIAS + 1) << cnn_pkg::FLOAT_MAN_W)
) (
    input  logic              clk,
    input  logic              rst,
    input  cnn_pkg::result_t  tree_sum,
    output cnn_pkg::result_t  activation
);
    import cnn_pkg::*;

    localparam int SIGN_BIT = FLOAT_EXP_W + FLOAT_MAN_W;

    float_t biased_d;
    float_t biased_q;
    logic   biased_valid;

    // --------------------
    // bias stage
    // --------------------

    fp_add u_bias_add (
        .a   (tree_sum.value),
        .b   (BIAS),
        .sum (biased_d)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            biased_valid <= 1'b0;
        end else begin
            biased_valid <= tree_sum.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (tree_sum.valid) begin
            biased_q <= biased_d;
        end
    end

    // --------------------
    // relu stage
    // --------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            activation <= '0;
        end else begin
            activation.valid <= biased_valid;
            if (biased_valid) begin
                // any set sign bit becomes +0, which also catches -0.
                activation.value <= biased_q[SIGN_BIT] ? '0 : biased_q;
            end
        end
    end

    a_relu_positive: assert property (
        @(posedge clk) disable iff (rst)
        activation.valid |-> !activation.value[SIGN_BIT]
    ) else $error("activation has its sign bit set.");

    a_relu_latency: assert property (
        @(posedge clk) disable iff (rst)
        activation.valid == $past(tree_sum.valid, 2)
    ) else $error("activation valid does not follow tree_sum valid by 2 cycles.");

endmodule

`default_nettype wire

//--- channel_sum_tree.sv
`default_nettype none

module channel_sum_tree #(
    parameter int NUM_CHANNELS = 16
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 in_valid,
    input  cnn_pkg::float_t [NUM_CHANNELS-1:0]   in_data,
    output cnn_pkg::result_t                     tree_sum
);
    import cnn_pkg::*;

    localparam int LEVELS = $clog2(NUM_CHANNELS);

    // all adder results live in one flat array, level by level.
    // level l starts at NUM_CHANNELS - (NUM_CHANNELS >> l).
    float_t node_d [NUM_CHANNELS-1];
    float_t node_q [NUM_CHANNELS-1];
    logic   valid_q [LEVELS];

    // --------------------
    // adder levels
    // --------------------

    for (genvar l = 0; l < LEVELS; l++) begin : g_level
        localparam int PAIRS    = NUM_CHANNELS >> (l + 1);
        localparam int OUT_BASE = NUM_CHANNELS - (NUM_CHANNELS >> l);
        localparam int IN_BASE  = OUT_BASE - 2 * PAIRS;

        logic load;  // valid bit of the rank this level reads.

        if (l == 0) begin : g_load
            assign load = in_valid;
        end else begin : g_load
            assign load = valid_q[l-1];
        end

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                valid_q[l] <= 1'b0;
            end else begin
                valid_q[l] <= load;
            end
        end

        for (genvar p = 0; p < PAIRS; p++) begin : g_pair
            float_t op_a;
            float_t op_b;

            if (l == 0) begin : g_src
                assign op_a = in_data[2*p];       // first level works on the raw inputs.
                assign op_b = in_data[2*p+1];
            end else begin : g_src
                assign op_a = node_q[IN_BASE + 2*p];
                assign op_b = node_q[IN_BASE + 2*p + 1];
            end

            fp_add u_fp_add (
                .a   (op_a),
                .b   (op_b),
                .sum (node_d[OUT_BASE + p])
            );

            always_ff @(posedge clk) begin
                if (load) begin
                    node_q[OUT_BASE + p] <= node_d[OUT_BASE + p];
                end
            end
        end
    end

    // the root is the last entry of the array.
    assign tree_sum.valid = valid_q[LEVELS-1];
    assign tree_sum.value = node_q[NUM_CHANNELS-2];

    // --------------------
    // checks
    // --------------------

    a_tree_latency: assert property (
        @(posedge clk) disable iff (rst)
        tree_sum.valid == $past(in_valid, LEVELS)
    ) else $error("tree_sum valid does not follow in_valid by %0d cycles.", LEVELS);

endmodule

`default_nettype wire

//--- cnn_pkg.sv
`default_nettype none

package cnn_pkg;

    // --------------------
    // float format
    // --------------------

    // IEEE-754 single precision laid out as sign, exponent, fraction.
    localparam int FLOAT_EXP_W = 8;     // exponent field width.
    localparam int FLOAT_MAN_W = 23;    // stored fraction width without the hidden bit.
    localparam int FLOAT_BIAS  = 127;   // exponent bias.

    typedef logic [FLOAT_EXP_W+FLOAT_MAN_W:0] float_t;

    // --------------------
    // strobed value
    // --------------------

    // the value is meaningful only in a cycle where valid is high.
    typedef struct packed {
        logic   valid;
        float_t value;
    } result_t;

endpackage

`default_nettype wire

//--- conv_output_stage.sv
`default_nettype none

module conv_output_stage #(
    parameter int NUM_CHANNELS = 16,   // power of two, at least 2.
    parameter cnn_pkg::float_t BIAS =
        cnn_pkg::float_t'((cnn_pkg::FLOAT_BIAS + 1) << cnn_pkg::FLOAT_MAN_W)
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 in_valid,
    input  cnn_pkg::float_t [NUM_CHANNELS-1:0]   in_data,
    output cnn_pkg::result_t                     activation
);
    import cnn_pkg::*;

    // total latency is log2(NUM_CHANNELS) + 2 cycles.

    result_t tree_sum;

    // --------------------
    // channel reduction
    // --------------------

    channel_sum_tree #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) u_channel_sum_tree (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_data  (in_data),
        .tree_sum (tree_sum)
    );

    // --------------------
    // bias and relu
    // --------------------

    bias_relu #(
        .BIAS (BIAS)
    ) u_bias_relu (
        .clk        (clk),
        .rst        (rst),
        .tree_sum   (tree_sum),
        .activation (activation)
    );

endmodule

`default_nettype wire

//--- fp_add.sv
`default_nettype none

module fp_add (
    input  cnn_pkg::float_t a,
    input  cnn_pkg::float_t b,
    output cnn_pkg::float_t sum
);
    import cnn_pkg::*;

    localparam int SB  = FLOAT_EXP_W + FLOAT_MAN_W;  // sign bit position.
    localparam int MW  = FLOAT_MAN_W + 1;            // mantissa with the hidden bit.
    localparam int AW  = MW + 3;                     // plus guard, round and sticky.
    localparam int SW  = FLOAT_EXP_W + 2;            // signed exponent with headroom.
    localparam int LZW = $clog2(AW);

    logic [FLOAT_EXP_W-1:0]  exp_a;
    logic [FLOAT_EXP_W-1:0]  exp_b;
    logic [MW-1:0]           man_a;
    logic [MW-1:0]           man_b;
    logic                    a_big;
    logic                    sign_l;
    logic                    sign_s;
    logic [FLOAT_EXP_W-1:0]  exp_l;
    logic [FLOAT_EXP_W-1:0]  exp_s;
    logic [MW-1:0]           man_l;
    logic [MW-1:0]           man_s;
    logic [FLOAT_EXP_W-1:0]  exp_diff;
    logic [FLOAT_EXP_W-1:0]  shift_amt;
    logic [MW+AW-2:0]        shifted;
    logic [AW-1:0]           aligned;
    logic                    eff_sub;
    logic [AW:0]             sum_raw;
    logic [LZW-1:0]          lz;
    logic [AW-1:0]           norm;
    logic signed [SW-1:0]    exp_norm;
    logic                    round_up;
    logic [MW:0]             man_rnd;
    logic [SW-1:0]           exp_rnd;
    logic [FLOAT_MAN_W-1:0]  frac_out;

    // --------------------
    // unpack and order
    // --------------------

    // subnormal operands have a zero exponent and are read as zero.
    assign exp_a = a[SB-1 -: FLOAT_EXP_W];
    assign exp_b = b[SB-1 -: FLOAT_EXP_W];
    assign man_a = (exp_a == '0) ? '0 : {1'b1, a[FLOAT_MAN_W-1:0]};
    assign man_b = (exp_b == '0) ? '0 : {1'b1, b[FLOAT_MAN_W-1:0]};

    assign a_big = {exp_a, man_a} >= {exp_b, man_b};

    always_comb begin
        if (a_big) begin
            sign_l = a[SB];
            exp_l  = exp_a;
            man_l  = man_a;
            sign_s = b[SB];
            exp_s  = exp_b;
            man_s  = man_b;
        end else begin
            sign_l = b[SB];
            exp_l  = exp_b;
            man_l  = man_b;
            sign_s = a[SB];
            exp_s  = exp_a;
            man_s  = man_a;
        end
    end

    // --------------------
    // align and add
    // --------------------

    // beyond AW places the smaller operand only feeds the sticky bit.
    assign exp_diff  = exp_l - exp_s;
    assign shift_amt = (exp_diff > FLOAT_EXP_W'(AW)) ? FLOAT_EXP_W'(AW) : exp_diff;
    assign shifted   = {man_s, {(AW-1){1'b0}}} >> shift_amt;
    assign aligned   = {shifted[MW+AW-2 -: AW-1], |shifted[MW-1:0]};

    assign eff_sub = sign_l ^ sign_s;
    assign sum_raw = eff_sub ? ({1'b0, man_l, 3'b000} - {1'b0, aligned})
                             : ({1'b0, man_l, 3'b000} + {1'b0, aligned});

    // --------------------
    // normalize and round
    // --------------------

    always_comb begin
        lz = '0;
        for (int i = 0; i < AW; i++) begin
            if (sum_raw[i]) begin
                lz = LZW'(AW - 1 - i);  // the highest set bit wins.
            end
        end
    end

    always_comb begin
        if (sum_raw[AW]) begin
            // a carry out shifts right once and folds the lost bit into sticky.
            norm     = {sum_raw[AW:2], sum_raw[1] | sum_raw[0]};
            exp_norm = SW'(exp_l) + SW'(1);
        end else begin
            norm     = sum_raw[AW-1:0] << lz;
            exp_norm = SW'(exp_l) - SW'(lz);
        end
    end

    // round to nearest, ties to the even mantissa.
    assign round_up = norm[2] & (norm[1] | norm[0] | norm[3]);
    assign man_rnd  = {1'b0, norm[AW-1:3]} + {{MW{1'b0}}, round_up};
    assign exp_rnd  = exp_norm + SW'(man_rnd[MW]);
    assign frac_out = man_rnd[FLOAT_MAN_W-1:0];  // a rounding carry leaves these bits zero.

    always_comb begin
        if (sum_raw == '0) begin
            sum = '0;  // exact cancellation is always +0.
        end else if (exp_norm <= 0) begin
            sum = {sign_l, {SB{1'b0}}};
        end else begin
            sum = {sign_l, exp_rnd[FLOAT_EXP_W-1:0], frac_out};
        end
    end

endmodule

`default_nettype wire

//--- tb_conv_output_stage.sv
`default_nettype none

module tb_conv_output_stage;
    timeunit 1ns;
    timeprecision 1ps;

    import cnn_pkg::*;

    localparam int     N_CH           = 16;
    localparam int     LATENCY        = $clog2(N_CH) + 2;  // tree levels plus bias and relu.
    localparam int     BIAS_INT       = 2;
    localparam float_t BIAS_BITS      = 32'h4000_0000;     // 2.0 in single precision.
    localparam int     RESET_CYCLES   = 10;
    localparam int     TIMEOUT_CYCLES = 2000;  // 400 vectors, up to 600 gap cycles, latency.

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  in_valid;
    float_t [N_CH-1:0]     in_data;
    result_t               activation;

    float_t                exp_q [$];
    float_t                exp_head = '0;
    int                    exp_count = 0;
    logic                  seen_input = 1'b0;
    logic [LATENCY-1:0]    valid_hist = '0;
    int                    cycle_count = 0;
    logic [31:0]           lfsr_state = 32'hc133a728;
    int                    chan [N_CH];

    always #5 clk = ~clk;

    conv_output_stage #(
        .NUM_CHANNELS (N_CH),
        .BIAS         (BIAS_BITS)
    ) dut_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .activation (activation)
    );

    // --------------------
    // helpers
    // --------------------

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // exact conversion for integers below 2**24.
    function automatic float_t int_to_float(input int v);
        int     mag;
        int     msb;
        float_t f;
        mag = (v < 0) ? -v : v;
        msb = 0;
        f   = '0;
        if (mag != 0) begin
            for (int i = 0; i < 24; i++) begin
                if (mag[i]) begin
                    msb = i;
                end
            end
            f[31]    = (v < 0);
            f[30:23] = 8'(FLOAT_BIAS + msb);
            f[22:0]  = 23'(mag << (FLOAT_MAN_W - msb));  // the hidden bit falls off the top.
        end
        return f;
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value      = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic refresh_head();
        exp_count = exp_q.size();
        exp_head  = (exp_count != 0) ? exp_q[0] : '0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // drives chan[] for one cycle and records the relu of the biased sum.
    task automatic send_vector();
        int total;
        total = 0;
        for (int i = 0; i < N_CH; i++) begin
            in_data[i] = int_to_float(chan[i]);
            total      = total + chan[i];
        end
        total = total + BIAS_INT;
        exp_q.push_back(int_to_float((total < 0) ? 0 : total));
        refresh_head();
        in_valid = 1'b1;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic run_random(input int count, input logic with_gaps);
        int r;
        for (int v = 0; v < count; v++) begin
            for (int i = 0; i < N_CH; i++) begin
                draw_bits(7, r);
                chan[i] = r - 64;
            end
            send_vector();
            if (with_gaps) begin
                draw_bits(2, r);
                idle(r);
            end
        end
    endtask

    // --------------------
    // checking
    // --------------------

    always @(posedge clk) begin
        valid_hist <= {valid_hist[LATENCY-2:0], in_valid};  // in_valid seen at past edges.
        if (!rst && in_valid) begin
            seen_input <= 1'b1;
        end
        if (!rst && activation.valid && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
            refresh_head();
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Run did not finish within %0d cycles.", TIMEOUT_CYCLES));
        end
    end

    a_quiet_before_input: assert property (
        @(posedge clk) disable iff (rst)
        !seen_input |-> (!activation.valid && activation.value == '0)
    ) else abort_run($sformatf("Mismatch activation got %h expected %h",
                               $sampled(activation), 33'h0));

    a_no_spurious: assert property (
        @(posedge clk) disable iff (rst)
        activation.valid |-> exp_count != 0
    ) else abort_run("An output strobe arrived with no input vector pending.");

    a_value: assert property (
        @(posedge clk) disable iff (rst)
        activation.valid |-> activation.value == exp_head
    ) else abort_run($sformatf("Mismatch activation.value got %h expected %h",
                               $sampled(activation.value), $sampled(exp_head)));

    a_latency: assert property (
        @(posedge clk) disable iff (rst)
        activation.valid == valid_hist[LATENCY-1]
    ) else abort_run($sformatf("Mismatch activation.valid got %h expected %h",
                               $sampled(activation.valid),
                               $sampled(valid_hist[LATENCY-1])));

    // --------------------
    // stimulus
    // --------------------

    initial begin
        rst      = 1'b1;
        in_valid = 1'b0;
        in_data  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        idle(5);  // output has to stay quiet here.

        for (int i = 0; i < N_CH; i++) begin
            chan[i] = 1;
        end
        send_vector();
        idle(LATENCY + 2);

        for (int i = 0; i < N_CH; i++) begin
            chan[i] = -1;  // sum plus bias is -14.
        end
        send_vector();
        idle(LATENCY + 2);

        for (int i = 0; i < N_CH; i++) begin
            chan[i] = (i == 0) ? -2 : 0;
        end
        send_vector();
        idle(LATENCY + 2);

        // each pair cancels at the first tree level.
        for (int i = 0; i < N_CH; i++) begin
            chan[i] = (i % 2 == 0) ? (i / 2 + 1) : -(i / 2 + 1);
        end
        send_vector();
        idle(LATENCY + 2);

        run_random(200, 1'b0);
        run_random(200, 1'b1);

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        #1;
        idle(LATENCY + 4);  // a late extra strobe would still be caught here.

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
cnn_pkg.sv
fp_add.sv
channel_sum_tree.sv
bias_relu.sv
conv_output_stage.sv
tb_conv_output_stage.sv
